// ==== Bender.yml ====
package:
  name: icache_fetch

sources:
  - icache_pkg.sv
  - icache_fetch_fsm.sv
  - icache_tags.sv
  - icache_plru.sv
  - icache_fill.sv
  - icache_fetch.sv
  - target: test
    files:
      - icache_checker.sv
      - tb_icache_fetch.sv

// ==== icache_checker.sv ====
module icache_checker #(
    parameter logic [icache_pkg::AXI_ADDR_W-1:0] CACHED_BASE  = 32'h8000_0000,
    parameter logic [icache_pkg::AXI_ADDR_W-1:0] CACHED_LIMIT = 32'h8800_0000
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_pkg::XLEN-1:0]         pc,
    input  logic                                fetch_en,
    input  logic                                fence_i,
    input  logic                                next_ready,
    input  logic                                ready,
    input  logic                                valid_out,
    input  logic                                hit,
    input  logic [icache_pkg::WAY_W-1:0]        hit_way,
    input  logic [icache_pkg::XLEN-1:0]         rdata,
    input  logic                                arvalid,
    input  logic [icache_pkg::AXI_ADDR_W-1:0]   araddr,
    input  logic [2:0]                          arsize,
    input  logic                                arready,
    input  logic                                rvalid,
    input  logic                                rready,
    input  logic                                fill_en,
    input  logic [icache_pkg::INDEX_W-1:0]      fill_set,
    input  logic [icache_pkg::WAY_W-1:0]        fill_way,
    input  logic [icache_pkg::XLEN-1:0]         fill_data,
    output int                                  checks,
    output int                                  errors
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [63:0] BEAT_MASK = 64'h5a5a_0000_a5a5_0000;

    logic                          vld    [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
    logic                          fenced [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
    logic [icache_pkg::TAG_W-1:0]  tags   [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
    logic [icache_pkg::PLRU_W-1:0] tree   [icache_pkg::NUM_SETS];
    logic                          busy;
    logic                          uncached;
    logic                          holding;
    logic                          addr_phase;
    logic                          data_phase;
    logic [31:0]                   req_addr;
    logic [63:0]                   held_data;

    function automatic logic [63:0] beat_value(input logic [31:0] addr);
        return {32'h0, addr} ^ BEAT_MASK;
    endfunction

    // walk from the root where a 0 node leads to the lower half.
    function automatic logic [2:0] plru_victim(input logic [6:0] t);
        logic upper;
        logic mid;
        upper = t[0];
        mid = upper ? t[2] : t[1];
        case ({upper, mid})
            2'b00:   return {upper, mid, t[3]};
            2'b01:   return {upper, mid, t[4]};
            2'b10:   return {upper, mid, t[5]};
            default: return {upper, mid, t[6]};
        endcase
    endfunction

    function automatic logic [6:0] plru_touch(input logic [6:0] t, input logic [2:0] w);
        logic [6:0] n;
        n = t;
        n[0] = !w[2];
        if (w[2]) begin
            n[2] = !w[1];
        end else begin
            n[1] = !w[1];
        end
        case (w[2:1])
            2'b00:   n[3] = !w[0];
            2'b01:   n[4] = !w[0];
            2'b10:   n[5] = !w[0];
            default: n[6] = !w[0];
        endcase
        return n;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    // ********************
    // reference model
    // ********************

    always @(negedge clk) begin : monitor
        logic [icache_pkg::INDEX_W-1:0] idx;
        logic [icache_pkg::TAG_W-1:0]   tg;
        logic                           in_window;
        logic                           exp_hit;
        logic                           was_fenced;
        logic                           found;
        logic [icache_pkg::WAY_W-1:0]   exp_way;
        string                          name;

        idx = pc[icache_pkg::INDEX_W+icache_pkg::OFFSET_W-1:icache_pkg::OFFSET_W];
        tg = pc[icache_pkg::XLEN-1:icache_pkg::INDEX_W+icache_pkg::OFFSET_W];
        in_window = (pc[31:0] >= CACHED_BASE) && (pc[31:0] < CACHED_LIMIT);
        if (rst) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                tree[s] = '0;
                for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                    vld[s][w] = 1'b0;
                    fenced[s][w] = 1'b0;
                end
            end
            busy = 1'b0;
            uncached = 1'b0;
            holding = 1'b0;
            addr_phase = 1'b0;
            data_phase = 1'b0;
            checks = 0;
            errors = 0;
        end else begin
            // read channel levels follow the bus phase of the current request.
            name = uncached ? "uncached_check" : "hit_check";
            compare(name, addr_phase, arvalid);
            compare(name, data_phase, rready);
            if (data_phase && rvalid) begin
                data_phase = 1'b0;
            end
            if (addr_phase && arready) begin
                addr_phase = 1'b0;
                data_phase = 1'b1;
            end
            if (fence_i) begin
                for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                        fenced[s][w] = fenced[s][w] || vld[s][w];
                        vld[s][w] = 1'b0;
                    end
                end
            end
            if (fill_en && !(busy && !uncached)) begin
                report_problem("fill_en pulsed with no line fill pending");
            end
            if (!busy && fetch_en && in_window) begin
                exp_hit = 1'b0;
                was_fenced = 1'b0;
                exp_way = '0;
                for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                    if (vld[idx][w] && tags[idx][w] == tg) begin
                        exp_hit = 1'b1;
                        exp_way = icache_pkg::WAY_W'(w);
                    end
                    if (fenced[idx][w] && tags[idx][w] == tg) begin
                        was_fenced = 1'b1;
                    end
                end
                name = (was_fenced && !exp_hit) ? "fence_check" : "hit_check";
                compare(name, exp_hit, hit);
                compare("hit_check", exp_hit, valid_out);
                if (exp_hit) begin
                    compare("hit_check", exp_way, hit_way);
                    compare("backpressure_check", next_ready, ready);
                    if (next_ready) begin
                        tree[idx] = plru_touch(tree[idx], exp_way);
                    end
                end else begin
                    busy = 1'b1;
                    uncached = 1'b0;
                    addr_phase = 1'b1;
                    req_addr = {pc[31:3], 3'b000};
                end
            end else if (!busy && fetch_en) begin
                busy = 1'b1;
                uncached = 1'b1;
                holding = 1'b0;
                addr_phase = 1'b1;
                req_addr = pc[31:0];
            end else if (busy && !uncached) begin
                if (arvalid) begin
                    compare("hit_check", req_addr, araddr);
                    compare("hit_check", icache_pkg::SIZE_DWORD, arsize);
                end
                if (fill_en) begin
                    found = 1'b0;
                    exp_way = plru_victim(tree[idx]);
                    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                        if (!found && !vld[idx][w]) begin
                            exp_way = icache_pkg::WAY_W'(w);
                            found = 1'b1;
                        end
                    end
                    compare("fill_check", idx, fill_set);
                    compare("fill_check", beat_value(req_addr), fill_data);
                    compare("fill_check", exp_way, fill_way);
                    vld[idx][exp_way] = 1'b1;
                    fenced[idx][exp_way] = 1'b0;
                    tags[idx][exp_way] = tg;
                    busy = 1'b0;
                end
            end else if (busy) begin
                if (arvalid) begin
                    compare("uncached_check", req_addr, araddr);
                    compare("uncached_check", icache_pkg::SIZE_WORD, arsize);
                end
                if (holding || valid_out) begin
                    if (!valid_out) begin
                        report_problem("valid_out dropped while an uncached result was held");
                    end else if (holding) begin
                        compare("backpressure_check", held_data, rdata);
                    end else begin
                        compare("uncached_check", beat_value(req_addr), rdata);
                        held_data = beat_value(req_addr);
                    end
                    compare("backpressure_check", next_ready, ready);
                    if (next_ready || !valid_out) begin
                        busy = 1'b0;
                        holding = 1'b0;
                    end else begin
                        holding = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== icache_fetch.f ====
icache_pkg.sv
icache_fetch_fsm.sv
icache_tags.sv
icache_plru.sv
icache_fill.sv
icache_fetch.sv
icache_checker.sv
tb_icache_fetch.sv

// ==== icache_fetch.sv ====
module icache_fetch #(
    parameter logic [icache_pkg::AXI_ADDR_W-1:0] CACHED_BASE  = 32'h8000_0000,
    parameter logic [icache_pkg::AXI_ADDR_W-1:0] CACHED_LIMIT = 32'h8800_0000
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_pkg::XLEN-1:0]         pc,
    input  logic                                fetch_en,
    input  logic                                fence_i,
    input  logic                                next_ready,
    input  logic                                arready,
    input  logic                                rvalid,
    input  logic [icache_pkg::XLEN-1:0]         rdata_axi,
    output logic                                ready,
    output logic                                valid_out,
    output logic                                hit,
    output logic [icache_pkg::WAY_W-1:0]        hit_way,
    output logic [icache_pkg::XLEN-1:0]         rdata,
    output logic                                arvalid,
    output logic [icache_pkg::AXI_ADDR_W-1:0]   araddr,
    output logic [2:0]                          arsize,
    output logic                                rready,
    output logic                                fill_en,
    output logic [icache_pkg::INDEX_W-1:0]      fill_set,
    output logic [icache_pkg::WAY_W-1:0]        fill_way,
    output logic [icache_pkg::XLEN-1:0]         fill_data
);

    icache_pkg::fetch_state_e state;

    logic [icache_pkg::TAG_W-1:0]    tag;
    logic [icache_pkg::INDEX_W-1:0]  index;
    logic                            cached;
    logic                            lookup_fire;
    logic [icache_pkg::XLEN-1:0]     line_data;
    logic [icache_pkg::NUM_WAYS-1:0] valid_mask;
    logic [icache_pkg::WAY_W-1:0]    victim_way;

    // ********************
    // address decode
    // ********************

    assign tag   = pc[icache_pkg::XLEN-1:icache_pkg::INDEX_W+icache_pkg::OFFSET_W];
    assign index = pc[icache_pkg::INDEX_W+icache_pkg::OFFSET_W-1:icache_pkg::OFFSET_W];

    assign cached = (pc[icache_pkg::AXI_ADDR_W-1:0] >= CACHED_BASE)
                 && (pc[icache_pkg::AXI_ADDR_W-1:0] < CACHED_LIMIT);

    icache_fetch_fsm #(
        .CACHED_BASE  (CACHED_BASE),
        .CACHED_LIMIT (CACHED_LIMIT)
    ) icache_fetch_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_en    (fetch_en),
        .cached      (cached),
        .hit         (hit),
        .next_ready  (next_ready),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata_axi   (rdata_axi),
        .pc          (pc),
        .state       (state),
        .lookup_fire (lookup_fire),
        .ready       (ready),
        .valid_out   (valid_out),
        .rdata       (rdata),
        .line_data   (line_data),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arsize      (arsize),
        .rready      (rready)
    );

    icache_tags icache_tags_i (
        .clk        (clk),
        .rst        (rst),
        .tag        (tag),
        .index      (index),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fence_i    (fence_i),
        .hit        (hit),
        .hit_way    (hit_way),
        .valid_mask (valid_mask)
    );

    icache_plru icache_plru_i (
        .clk         (clk),
        .rst         (rst),
        .index       (index),
        .hit_way     (hit_way),
        .lookup_fire (lookup_fire),
        .victim_way  (victim_way)
    );

    icache_fill icache_fill_i (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .index      (index),
        .valid_mask (valid_mask),
        .victim_way (victim_way),
        .line_data  (line_data),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_set   (fill_set),
        .fill_data  (fill_data)
    );

endmodule

// ==== icache_fetch_fsm.sv ====
module icache_fetch_fsm #(
    parameter logic [icache_pkg::AXI_ADDR_W-1:0] CACHED_BASE  = 32'h8000_0000,
    parameter logic [icache_pkg::AXI_ADDR_W-1:0] CACHED_LIMIT = 32'h8800_0000
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                fetch_en,
    input  logic                                cached,
    input  logic                                hit,
    input  logic                                next_ready,
    input  logic                                arready,
    input  logic                                rvalid,
    input  logic [icache_pkg::XLEN-1:0]         rdata_axi,
    input  logic [icache_pkg::XLEN-1:0]         pc,
    output icache_pkg::fetch_state_e            state,
    output logic                                lookup_fire,
    output logic                                ready,
    output logic                                valid_out,
    output logic [icache_pkg::XLEN-1:0]         rdata,
    output logic [icache_pkg::XLEN-1:0]         line_data,
    output logic                                arvalid,
    output logic [icache_pkg::AXI_ADDR_W-1:0]   araddr,
    output logic [2:0]                          arsize,
    output logic                                rready
);

    icache_pkg::fetch_state_e state_next;

    logic                              uncached_q;
    logic [icache_pkg::AXI_ADDR_W-1:0] req_addr;
    logic [icache_pkg::XLEN-1:0]       data_q;
    logic                              start_hit;
    logic                              data_fire;

    assign start_hit   = (state == icache_pkg::fs_start) && fetch_en && cached && hit;
    assign lookup_fire = start_hit && next_ready;

    // uncached beat goes straight out in the rvalid cycle.
    assign data_fire = (state == icache_pkg::fs_data) && rvalid && uncached_q;

    // ********************
    // state machine
    // ********************

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::fs_start: begin
                if (fetch_en && !(cached && hit)) begin
                    state_next = icache_pkg::fs_addr;
                end
            end
            icache_pkg::fs_addr: begin
                if (arready) begin
                    state_next = icache_pkg::fs_data;
                end
            end
            icache_pkg::fs_data: begin
                if (rvalid) begin
                    if (!uncached_q) begin
                        state_next = icache_pkg::fs_fill;
                    end else if (next_ready) begin
                        state_next = icache_pkg::fs_start;
                    end else begin
                        state_next = icache_pkg::fs_hold;
                    end
                end
            end
            icache_pkg::fs_fill: begin
                state_next = icache_pkg::fs_start;
            end
            icache_pkg::fs_hold: begin
                if (next_ready) begin
                    state_next = icache_pkg::fs_start;
                end
            end
            default: begin
                state_next = icache_pkg::fs_start;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= icache_pkg::fs_start;
            uncached_q <= 1'b0;
        end else begin
            state <= state_next;
            if (state == icache_pkg::fs_start && state_next == icache_pkg::fs_addr) begin
                uncached_q <= !cached;
            end
        end
    end

    // request address is frozen when the miss leaves fs_start.
    always_ff @(posedge clk) begin
        if (state == icache_pkg::fs_start && state_next == icache_pkg::fs_addr) begin
            if (cached) begin
                req_addr <= {pc[icache_pkg::AXI_ADDR_W-1:icache_pkg::OFFSET_W],
                             {icache_pkg::OFFSET_W{1'b0}}};
            end else begin
                req_addr <= pc[icache_pkg::AXI_ADDR_W-1:0];
            end
        end
        if (state == icache_pkg::fs_data && rvalid) begin
            data_q <= rdata_axi;
        end
    end

    // ********************
    // outputs
    // ********************

    assign arvalid   = (state == icache_pkg::fs_addr);
    assign rready    = (state == icache_pkg::fs_data);
    assign araddr    = req_addr;
    assign arsize    = uncached_q ? icache_pkg::SIZE_WORD : icache_pkg::SIZE_DWORD;
    assign line_data = data_q;
    assign rdata     = (state == icache_pkg::fs_data) ? rdata_axi : data_q;
    assign valid_out = start_hit || data_fire || (state == icache_pkg::fs_hold);

    always_comb begin
        ready = 1'b0;
        if (state == icache_pkg::fs_start) begin
            ready = !fetch_en || (start_hit && next_ready);
        end else if (data_fire || state == icache_pkg::fs_hold) begin
            ready = next_ready;
        end
    end

    addr_stable_a: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // a line request only ever targets the cacheable window.
    dword_window_a: assert property (@(posedge clk) disable iff (rst)
        arvalid && arsize == icache_pkg::SIZE_DWORD
        |-> araddr >= CACHED_BASE && araddr < CACHED_LIMIT);

endmodule

// ==== icache_fill.sv ====
module icache_fill (
    input  logic                                clk,
    input  logic                                rst,
    input  icache_pkg::fetch_state_e            state,
    input  logic [icache_pkg::INDEX_W-1:0]      index,
    input  logic [icache_pkg::NUM_WAYS-1:0]     valid_mask,
    input  logic [icache_pkg::WAY_W-1:0]        victim_way,
    input  logic [icache_pkg::XLEN-1:0]         line_data,
    output logic                                fill_en,
    output logic [icache_pkg::WAY_W-1:0]        fill_way,
    output logic [icache_pkg::INDEX_W-1:0]      fill_set,
    output logic [icache_pkg::XLEN-1:0]         fill_data
);

    // lowest invalid way wins, plru victim when the set is full.
    always_comb begin
        fill_way = victim_way;
        for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                fill_way = icache_pkg::WAY_W'(w);
            end
        end
    end

    assign fill_en   = (state == icache_pkg::fs_fill);
    assign fill_set  = index;
    assign fill_data = line_data;

    single_fill_a: assert property (@(posedge clk) disable iff (rst)
        fill_en |=> !fill_en);

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

    // ********************
    // cache geometry
    // ********************

    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 64;
    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int OFFSET_W = 3;
    localparam int XLEN     = 64;

    // pc bits above index and offset.
    localparam int TAG_W    = XLEN - INDEX_W - OFFSET_W;

    // one node per internal vertex of the way tree.
    localparam int PLRU_W   = NUM_WAYS - 1;

    // ********************
    // read bus
    // ********************

    localparam int AXI_ADDR_W = 32;

    localparam logic [2:0] SIZE_WORD  = 3'b010;
    localparam logic [2:0] SIZE_DWORD = 3'b011;

    typedef enum logic [2:0] {
        fs_start = 3'd0,
        fs_addr  = 3'd1,
        fs_data  = 3'd2,
        fs_fill  = 3'd3,
        fs_hold  = 3'd4
    } fetch_state_e;

endpackage

// ==== icache_plru.sv ====
module icache_plru (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_pkg::INDEX_W-1:0]      index,
    input  logic [icache_pkg::WAY_W-1:0]        hit_way,
    input  logic                                lookup_fire,
    output logic [icache_pkg::WAY_W-1:0]        victim_way
);

    logic [icache_pkg::PLRU_W-1:0] tree_q [icache_pkg::NUM_SETS];
    logic [icache_pkg::PLRU_W-1:0] tree;
    logic [icache_pkg::PLRU_W-1:0] tree_upd;
    logic                          root;
    logic                          pair;
    logic                          leaf;

    assign tree = tree_q[index];

    // ********************
    // victim walk
    // ********************

    // 0 points to the lower half, 1 to the upper half.
    assign root = tree[0];
    assign pair = tree[1 + root];
    assign leaf = tree[3 + {root, pair}];

    assign victim_way = {root, pair, leaf};

    // ********************
    // hit update
    // ********************

    // every node on the path is turned away from the way just used.
    always_comb begin
        tree_upd = tree;
        tree_upd[0] = ~hit_way[2];
        tree_upd[1 + hit_way[2]] = ~hit_way[1];
        tree_upd[3 + hit_way[2:1]] = ~hit_way[0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (lookup_fire) begin
            tree_q[index] <= tree_upd;
        end
    end

endmodule

// ==== icache_tags.sv ====
module icache_tags (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_pkg::TAG_W-1:0]        tag,
    input  logic [icache_pkg::INDEX_W-1:0]      index,
    input  logic                                fill_en,
    input  logic [icache_pkg::WAY_W-1:0]        fill_way,
    input  logic                                fence_i,
    output logic                                hit,
    output logic [icache_pkg::WAY_W-1:0]        hit_way,
    output logic [icache_pkg::NUM_WAYS-1:0]     valid_mask
);

    logic [icache_pkg::NUM_WAYS-1:0] valid_q [icache_pkg::NUM_SETS];
    logic [icache_pkg::TAG_W-1:0]    tag_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
    logic [icache_pkg::NUM_WAYS-1:0] way_hit;

    assign valid_mask = valid_q[index];

    // ********************
    // lookup
    // ********************

    always_comb begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            way_hit[w] = valid_q[index][w] && (tag_mem[w][index] == tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = icache_pkg::WAY_W'(w);
            end
        end
    end

    assign hit = |way_hit;

    // ********************
    // update
    // ********************

    // fence is ignored while a fill is being written.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_en) begin
            valid_q[index][fill_way] <= 1'b1;
        end else if (fence_i) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][index] <= tag;
        end
    end

    one_hit_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0(way_hit));

endmodule

// ==== tb_icache_fetch.sv ====
module tb_icache_fetch;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] CACHED_BASE  = 32'h8000_0000;
    localparam logic [31:0] CACHED_LIMIT = 32'h8800_0000;
    localparam logic [63:0] BEAT_MASK    = 64'h5a5a_0000_a5a5_0000;

    localparam int NUM_FETCHES      = 400;
    localparam int CYCLES_PER_FETCH = 12;
    localparam int MAX_CYCLES       = NUM_FETCHES * CYCLES_PER_FETCH;

    logic                                clk;
    logic                                rst;
    logic [icache_pkg::XLEN-1:0]         pc;
    logic                                fetch_en;
    logic                                fence_i;
    logic                                next_ready;
    logic                                arready;
    logic                                rvalid;
    logic [icache_pkg::XLEN-1:0]         rdata_axi;
    logic                                ready;
    logic                                valid_out;
    logic                                hit;
    logic [icache_pkg::WAY_W-1:0]        hit_way;
    logic [icache_pkg::XLEN-1:0]         rdata;
    logic                                arvalid;
    logic [icache_pkg::AXI_ADDR_W-1:0]   araddr;
    logic [2:0]                          arsize;
    logic                                rready;
    logic                                fill_en;
    logic [icache_pkg::INDEX_W-1:0]      fill_set;
    logic [icache_pkg::WAY_W-1:0]        fill_way;
    logic [icache_pkg::XLEN-1:0]         fill_data;

    integer      seed;
    int          fetches;
    int          checks;
    int          errors;
    logic        rd_pending;
    logic [1:0]  rd_wait;
    logic [1:0]  ar_wait;
    logic [31:0] rd_addr;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    icache_fetch #(
        .CACHED_BASE  (CACHED_BASE),
        .CACHED_LIMIT (CACHED_LIMIT)
    ) icache_fetch_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .fetch_en   (fetch_en),
        .fence_i    (fence_i),
        .next_ready (next_ready),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata_axi  (rdata_axi),
        .ready      (ready),
        .valid_out  (valid_out),
        .hit        (hit),
        .hit_way    (hit_way),
        .rdata      (rdata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arsize     (arsize),
        .rready     (rready),
        .fill_en    (fill_en),
        .fill_set   (fill_set),
        .fill_way   (fill_way),
        .fill_data  (fill_data)
    );

    icache_checker #(
        .CACHED_BASE  (CACHED_BASE),
        .CACHED_LIMIT (CACHED_LIMIT)
    ) icache_checker_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .fetch_en   (fetch_en),
        .fence_i    (fence_i),
        .next_ready (next_ready),
        .ready      (ready),
        .valid_out  (valid_out),
        .hit        (hit),
        .hit_way    (hit_way),
        .rdata      (rdata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arsize     (arsize),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .fill_en    (fill_en),
        .fill_set   (fill_set),
        .fill_way   (fill_way),
        .fill_data  (fill_data),
        .checks     (checks),
        .errors     (errors)
    );

    // ********************
    // stimulus
    // ********************

    // 11 tags over 4 sets so that sets overflow and a quarter fall outside the window.
    function automatic logic [63:0] pick_pc(input logic [31:0] r);
        logic [31:0] lo;
        if (r[1:0] == 2'b00) begin
            lo = 32'h0001_0000 + {18'h0, r[13:2], 2'b00};
        end else begin
            lo = CACHED_BASE + {19'h0, r[7:4] % 4'd11, r[9:8], 4'h0, r[10], 2'b00};
        end
        return {32'h0, lo};
    endfunction

    // a new pc or a fence only once the previous fetch was taken.
    task automatic drive_fetch(input logic idle);
        logic [31:0] r;
        r = $random(seed);
        fence_i = 1'b0;
        next_ready = (r[1:0] != 2'b00);
        if (idle) begin
            if (r[6:2] == 5'd0) begin
                fetch_en = 1'b0;
                fence_i = 1'b1;
            end else if (r[4:2] == 3'd1) begin
                fetch_en = 1'b0;
            end else begin
                fetch_en = 1'b1;
                pc = pick_pc($random(seed));
            end
        end
    endtask

    // single-beat read slave with 0 to 3 wait cycles on each channel.
    task automatic respond(input logic arvalid_s, input logic [31:0] araddr_s,
                           input logic rready_s);
        logic [31:0] r;
        if (rvalid && rready_s) begin
            rvalid = 1'b0;
            rd_pending = 1'b0;
        end
        if (arvalid_s && arready) begin
            r = $random(seed);
            rd_pending = 1'b1;
            rd_addr = araddr_s;
            ar_wait = r[1:0];
            rd_wait = r[3:2];
        end else if (arvalid_s && ar_wait != 2'd0) begin
            ar_wait = ar_wait - 2'd1;
        end
        arready = !rd_pending && (ar_wait == 2'd0);
        if (rd_pending && !rvalid) begin
            if (rd_wait == 2'd0) begin
                rvalid = 1'b1;
                rdata_axi = {32'h0, rd_addr} ^ BEAT_MASK;
            end else begin
                rd_wait = rd_wait - 2'd1;
            end
        end
    endtask

    initial begin : stimulus
        logic        idle;
        logic        arvalid_s;
        logic        rready_s;
        logic [31:0] araddr_s;
        seed = 32'h24926ddb;
        fetches = 0;
        pc = '0;
        fetch_en = 1'b0;
        fence_i = 1'b0;
        next_ready = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata_axi = '0;
        rd_pending = 1'b0;
        rd_wait = 2'd0;
        ar_wait = 2'd0;
        rd_addr = '0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        while (fetches < NUM_FETCHES) begin
            @(negedge clk);
            idle = ready;
            arvalid_s = arvalid;
            araddr_s = araddr;
            rready_s = rready;
            if (fetch_en && ready) begin
                fetches++;
            end
            @(posedge clk);
            #2;
            drive_fetch(idle);
            respond(arvalid_s, araddr_s, rready_s);
        end
        @(negedge clk);
        $display("fetches %0d, checks %0d, errors %0d", fetches, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with only %0d of %0d fetches done",
                 cycles, fetches, NUM_FETCHES);
        $display("fetches %0d, checks %0d, errors %0d", fetches, checks, errors + 1);
        $display("Test FAILED");
        $finish;
    end

endmodule
